//--- Makefile
# Verilator simulation of the frequency monitor

VERILATOR ?= verilator
TOP       ?= tb_freq_monitor
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

# a crashed run also counts as a failure
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "sim failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "sim failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- clock_channel.sv
// one measured clock: prescaler in its own domain, toggle synchronizer and gate counter
// the prescaler has no reset and starts from its initial value
// toggles faster than half of ref_clk are lost in the synchronizer
`timescale 1ns/1ps

module clock_channel (
	input  logic          ref_clk,
	input  logic          rst_n,
	input  logic          meas_clk,
	input  logic          gate,
	freq_result_if.src    res
);

	import freq_cfg_pkg::*;
	import freq_rd_pkg::*;

	logic [PRESCALE_LOG2-1:0] pre_cnt = '0;
	logic                     pre_tgl = 1'b0;
	logic [SYNC_STAGES-1:0]   sync_q;
	logic                     tgl_last;
	logic                     tgl_edge;
	logic [COUNT_W-1:0]       edge_cnt;
	logic                     sat;

	// free running prescaler on the measured clock
	// the toggle flips each time the counter wraps, once per 2**PRESCALE_LOG2 edges
	always_ff @(posedge meas_clk) begin
		pre_cnt <= pre_cnt + 1'b1;
		if (&pre_cnt) begin
			pre_tgl <= ~pre_tgl;
		end
	end

	// synchronizer chain into ref_clk plus one history flop for edge detection
	always_ff @(posedge ref_clk) begin
		sync_q   <= {sync_q[SYNC_STAGES-2:0], pre_tgl};
		tgl_last <= sync_q[SYNC_STAGES-1];
	end

	// either direction of the toggle is one prescaled period
	assign tgl_edge = sync_q[SYNC_STAGES-1] ^ tgl_last;

	// gate counter, the result is handed over and the count restarts in the cycle after gate
	// an edge that lands on the gate cycle itself opens the next window
	always_ff @(posedge ref_clk) begin
		if (!rst_n) begin
			edge_cnt     <= '0;
			sat          <= 1'b0;
			res.count    <= '0;
			res.overflow <= 1'b0;
			res.stopped  <= 1'b0;
			res.update   <= 1'b0;
		end else begin
			res.update <= gate;
			if (gate) begin
				res.count    <= edge_cnt;
				res.overflow <= sat;
				res.stopped  <= (edge_cnt == '0);
				edge_cnt     <= COUNT_W'(tgl_edge);
				sat          <= 1'b0;
			end else if (tgl_edge) begin
				// at the ceiling the count holds and the loss is remembered
				if (edge_cnt == COUNT_MAX) begin
					sat <= 1'b1;
				end else begin
					edge_cnt <= edge_cnt + 1'b1;
				end
			end
		end
	end

	// a remembered overflow only ever sits on a count held at its ceiling
	a_count_sat: assert property (
		@(posedge ref_clk) disable iff (!rst_n) sat |-> (edge_cnt == COUNT_MAX)
	);

	// a result is handed over only in the cycle after a gate
	a_update_after_gate: assert property (
		@(posedge ref_clk) disable iff (!rst_n) res.update |-> $past(gate)
	);

endmodule

//--- freq_cfg_pkg.sv
// measurement constants, scaled for simulation rather than a one second window
// measured clocks above half of ref_clk times the prescale are not supported
package freq_cfg_pkg;

	// number of measured clocks, one channel each
	localparam int NUM_CLOCKS = 4;

	// the gate is TICK_DIV * GATE_TICKS ref_clk cycles long, 1000 here
	localparam int TICK_DIV   = 50;
	localparam int GATE_TICKS = 20;

	// counter widths for the gate timer, derived so that they track the values above
	localparam int TICK_W = $clog2(TICK_DIV);
	localparam int GATE_W = $clog2(GATE_TICKS);

	// each prescaled toggle stands for 2**PRESCALE_LOG2 measured edges
	localparam int PRESCALE_LOG2 = 4;

	// length of the synchronizer chain into the ref_clk domain
	localparam int SYNC_STAGES = 3;

	// width of a channel's gate count
	localparam int COUNT_W = 9;

endpackage

//--- freq_monitor_top.sv
// frequency monitor for NUM_CLOCKS free running clocks against ref_clk
// a result becomes visible 2 ref_clk cycles after the gate and stays until the next one
// rd_sel must address an existing channel
`timescale 1ns/1ps

module freq_monitor_top (
	input  logic                                ref_clk,
	input  logic                                rst_n,
	input  logic [freq_cfg_pkg::NUM_CLOCKS-1:0] meas_clk,
	input  logic [freq_rd_pkg::SEL_W-1:0]       rd_sel,
	input  logic                                sticky_clr,
	output logic [freq_cfg_pkg::COUNT_W-1:0]    rd_count,
	output logic                                rd_overflow,
	output logic                                rd_stopped,
	output logic [freq_cfg_pkg::NUM_CLOCKS-1:0] sticky_ovf,
	output logic                                update
);

	import freq_cfg_pkg::*;

	logic gate;

	// one result link per channel
	freq_result_if res_if [NUM_CLOCKS] ();

	// shared measurement window
	gate_timer i_gate_timer (
		.ref_clk (ref_clk),
		.rst_n   (rst_n),
		.gate    (gate)
	);

	// one channel per measured clock, all opened and closed by the same gate
	for (genvar i = 0; i < NUM_CLOCKS; i++) begin : g_chan
		clock_channel i_clock_channel (
			.ref_clk  (ref_clk),
			.rst_n    (rst_n),
			.meas_clk (meas_clk[i]),
			.gate     (gate),
			.res      (res_if[i])
		);
	end

	// snapshot, channel select and sticky flags
	result_readout i_result_readout (
		.ref_clk     (ref_clk),
		.rst_n       (rst_n),
		.res         (res_if),
		.rd_sel      (rd_sel),
		.sticky_clr  (sticky_clr),
		.rd_count    (rd_count),
		.rd_overflow (rd_overflow),
		.rd_stopped  (rd_stopped),
		.sticky_ovf  (sticky_ovf),
		.update      (update)
	);

endmodule

//--- freq_rd_pkg.sv
// readout constants seen at the top level ports
// the saturation value follows the count width of the measurement package
package freq_rd_pkg;

	// host channel select, wide enough to address every channel
	localparam int SEL_W = $clog2(freq_cfg_pkg::NUM_CLOCKS);

	// counts stop at this value and the overflow flag is raised instead
	localparam logic [freq_cfg_pkg::COUNT_W-1:0] COUNT_MAX = '1;

endpackage

//--- freq_result_if.sv
// one channel's gate result, driven by the channel and read by the readout
// update is a single cycle pulse, there is no back-pressure
`timescale 1ns/1ps

interface freq_result_if;

	import freq_cfg_pkg::*;

	// edges seen during the last gate, saturated
	logic [COUNT_W-1:0] count;

	// the count hit its ceiling during the last gate
	logic overflow;

	// no edge at all was seen during the last gate
	logic stopped;

	// pulses for one cycle when the three fields above are fresh
	logic update;

	// channel side
	modport src (
		output count,
		output overflow,
		output stopped,
		output update
	);

	// readout side
	modport dst (
		input count,
		input overflow,
		input stopped,
		input update
	);

endinterface

//--- gate_timer.sv
// periodic measurement gate, TICK_DIV * GATE_TICKS ref_clk cycles apart
// the first gate comes one full period after rst_n is released
`timescale 1ns/1ps

module gate_timer (
	input  logic ref_clk,
	input  logic rst_n,
	output logic gate
);

	import freq_cfg_pkg::*;

	logic [TICK_W-1:0] tick_cnt;
	logic              tick_max;
	logic [GATE_W-1:0] gate_cnt;

	// tick divider, the compare looks one count ahead so tick_max is a registered pulse
	always_ff @(posedge ref_clk) begin
		if (!rst_n) begin
			tick_cnt <= '0;
			tick_max <= 1'b0;
		end else begin
			tick_max <= (tick_cnt == TICK_W'(TICK_DIV - 2));
			if (tick_max) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// gate counter advances once per tick
	// gate is registered from the compare so it is a clean single cycle pulse
	always_ff @(posedge ref_clk) begin
		if (!rst_n) begin
			gate_cnt <= '0;
			gate     <= 1'b0;
		end else begin
			gate <= tick_max && (gate_cnt == GATE_W'(GATE_TICKS - 1));
			if (tick_max) begin
				if (gate_cnt == GATE_W'(GATE_TICKS - 1)) begin
					gate_cnt <= '0;
				end else begin
					gate_cnt <= gate_cnt + 1'b1;
				end
			end
		end
	end

	// the gate never stretches into a second cycle
	a_gate_single: assert property (
		@(posedge ref_clk) disable iff (!rst_n) gate |=> !gate
	);

endmodule

//--- list.f
freq_cfg_pkg.sv
freq_rd_pkg.sv
freq_result_if.sv
gate_timer.sv
clock_channel.sv
result_readout.sv
freq_monitor_top.sv
tb_freq_monitor.sv

//--- result_readout.sv
// snapshot of every channel from the same gate, one channel shown at a time
// a snapshot not read before the next gate is overwritten
// sticky_clr clears all sticky overflow bits and wins over a new overflow
`timescale 1ns/1ps

module result_readout (
	input  logic                                ref_clk,
	input  logic                                rst_n,
	freq_result_if.dst                          res [freq_cfg_pkg::NUM_CLOCKS],
	input  logic [freq_rd_pkg::SEL_W-1:0]       rd_sel,
	input  logic                                sticky_clr,
	output logic [freq_cfg_pkg::COUNT_W-1:0]    rd_count,
	output logic                                rd_overflow,
	output logic                                rd_stopped,
	output logic [freq_cfg_pkg::NUM_CLOCKS-1:0] sticky_ovf,
	output logic                                update
);

	import freq_cfg_pkg::*;

	logic [COUNT_W-1:0]    ch_count [NUM_CLOCKS];
	logic [NUM_CLOCKS-1:0] ch_ovf;
	logic [NUM_CLOCKS-1:0] ch_stop;
	logic [NUM_CLOCKS-1:0] ch_upd;
	logic                  any_upd;
	logic [COUNT_W-1:0]    snap_count [NUM_CLOCKS];
	logic [NUM_CLOCKS-1:0] snap_ovf;
	logic [NUM_CLOCKS-1:0] snap_stop;

	// interface array elements can only be indexed by a constant, so flatten them here
	for (genvar i = 0; i < NUM_CLOCKS; i++) begin : g_ch
		assign ch_count[i] = res[i].count;
		assign ch_ovf[i]   = res[i].overflow;
		assign ch_stop[i]  = res[i].stopped;
		assign ch_upd[i]   = res[i].update;
	end

	// all channels share one gate, so any update stands for all of them
	assign any_upd = |ch_upd;

	// every channel is captured in the same cycle so one read never mixes two gates
	always_ff @(posedge ref_clk) begin
		if (!rst_n) begin
			for (int i = 0; i < NUM_CLOCKS; i++) begin
				snap_count[i] <= '0;
			end
			snap_ovf  <= '0;
			snap_stop <= '0;
			update    <= 1'b0;
		end else begin
			update <= any_upd;
			if (any_upd) begin
				for (int i = 0; i < NUM_CLOCKS; i++) begin
					snap_count[i] <= ch_count[i];
				end
				snap_ovf  <= ch_ovf;
				snap_stop <= ch_stop;
			end
		end
	end

	// sticky overflow, set alongside the snapshot, cleared by the host
	always_ff @(posedge ref_clk) begin
		if (!rst_n) begin
			sticky_ovf <= '0;
		end else if (sticky_clr) begin
			sticky_ovf <= '0;
		end else if (any_upd) begin
			sticky_ovf <= sticky_ovf | ch_ovf;
		end
	end

	// host view of the selected channel
	assign rd_count    = snap_count[rd_sel];
	assign rd_overflow = snap_ovf[rd_sel];
	assign rd_stopped  = snap_stop[rd_sel];

	// the channels run off one gate, so their updates must line up
	a_updates_aligned: assert property (
		@(posedge ref_clk) disable iff (!rst_n) (ch_upd != '0) |-> (ch_upd == '1)
	);

endmodule

//--- tb_freq_monitor.sv
// testbench for freq_monitor_top, written for exactly four measured clocks
// measured clock edges start off the ref_clk grid so a sample never ties with an edge
// counts are accepted within one of the reference because the clock phases are free
`timescale 1ns/1ps

module tb_freq_monitor;

	import freq_cfg_pkg::*;
	import freq_rd_pkg::*;

	localparam int REF_HALF_NS   = 5;
	localparam int GATE_CYCLES   = TICK_DIV * GATE_TICKS;
	localparam int GATE_NS       = GATE_CYCLES * 2 * REF_HALF_NS;
	localparam int PRESCALE      = 1 << PRESCALE_LOG2;
	localparam int COUNT_LIMIT   = (1 << COUNT_W) - 1;
	localparam int PLANNED_GATES = 9;
	localparam int WATCHDOG_NS   = (PLANNED_GATES * GATE_CYCLES + 500) * 2 * REF_HALF_NS;

	logic                  ref_clk    = 1'b0;
	logic                  rst_n      = 1'b0;
	logic [SEL_W-1:0]      rd_sel     = '0;
	logic                  sticky_clr = 1'b0;
	logic                  mclk0      = 1'b0;
	logic                  mclk1      = 1'b0;
	logic                  mclk2      = 1'b0;
	logic                  mclk3      = 1'b0;
	logic [NUM_CLOCKS-1:0] meas_clk;
	logic [COUNT_W-1:0]    rd_count;
	logic                  rd_overflow;
	logic                  rd_stopped;
	logic [NUM_CLOCKS-1:0] sticky_ovf;
	logic                  update;

	// a period of 0 ns means the clock is held still
	int          period_ns [NUM_CLOCKS];
	realtime     half_ns [NUM_CLOCKS] = '{5.0, 5.0, 5.0, 5.0};
	int          got_count [NUM_CLOCKS];
	int          got_ovf [NUM_CLOCKS];
	int          got_stop [NUM_CLOCKS];
	logic [31:0] lfsr_state = 32'h742cfc18;
	int          errors     = 0;
	int          checks     = 0;
	int          gates_done = 0;
	int          cyc        = 0;
	int          last_upd   = -1;
	bit          armed      = 1'b0;

	always #(REF_HALF_NS) ref_clk = ~ref_clk;

	// each measured clock keeps running at its last half period, stopped ones just hold
	initial begin
		#0.37;
		forever begin
			#(half_ns[0]);
			mclk0 = (period_ns[0] != 0) ? ~mclk0 : mclk0;
		end
	end
	initial begin
		#0.61;
		forever begin
			#(half_ns[1]);
			mclk1 = (period_ns[1] != 0) ? ~mclk1 : mclk1;
		end
	end
	initial begin
		#0.13;
		forever begin
			#(half_ns[2]);
			mclk2 = (period_ns[2] != 0) ? ~mclk2 : mclk2;
		end
	end
	initial begin
		#0.89;
		forever begin
			#(half_ns[3]);
			mclk3 = (period_ns[3] != 0) ? ~mclk3 : mclk3;
		end
	end
	assign meas_clk = {mclk3, mclk2, mclk1, mclk0};

	freq_monitor_top i_freq_monitor_top (
		.ref_clk     (ref_clk),
		.rst_n       (rst_n),
		.meas_clk    (meas_clk),
		.rd_sel      (rd_sel),
		.sticky_clr  (sticky_clr),
		.rd_count    (rd_count),
		.rd_overflow (rd_overflow),
		.rd_stopped  (rd_stopped),
		.sticky_ovf  (sticky_ovf),
		.update      (update)
	);

	// Fibonacci LFSR with taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// edges the prescaler hands over in one gate, before saturation
	function automatic int edges_in_gate(input int p);
		if (p == 0) begin
			return 0;
		end
		return GATE_NS / (p * PRESCALE);
	endfunction

	// reference count as the host should see it
	function automatic int expected_count(input int p);
		int raw;
		raw = edges_in_gate(p);
		return (raw > COUNT_LIMIT) ? COUNT_LIMIT : raw;
	endfunction

	task automatic check_value(input string msg, input int got, input int exp, input int tol);
		int diff;
		diff = got - exp;
		checks++;
		if (diff > tol || diff < -tol) begin
			errors++;
			$display("FAILED at %0t: %s, got %0d, expected %0d", $time, msg, got, exp);
		end
	endtask

	// one LFSR step for every bit taken
	task automatic draw_bits(input int n, output int val);
		val = 0;
		for (int k = 0; k < n; k++) begin
			lfsr_state = lfsr_next(lfsr_state);
			val = (val << 1) | int'(lfsr_state[0]);
		end
	endtask

	task automatic set_period(input int ch, input int p);
		period_ns[ch] = p;
		if (p > 0) begin
			half_ns[ch] = p / 2.0;
		end
	endtask

	// periods from 4 ns to 60 ns
	task automatic random_period(input int ch);
		int r;
		draw_bits(6, r);
		set_period(ch, 4 + r % 57);
	endtask

	task automatic wait_gates(input int n);
		int target;
		target = gates_done + n;
		wait (gates_done >= target);
	endtask

	// the first gate after a change holds a mix of old and new periods and is skipped
	task automatic measure_after_change();
		armed = 1'b0;
		wait_gates(1);
		armed = 1'b1;
		wait_gates(1);
	endtask

	task automatic check_idle_outputs(input string when);
		check_value({"update ", when}, int'(update), 0, 0);
		check_value({"rd_overflow ", when}, int'(rd_overflow), 0, 0);
		check_value({"sticky_ovf ", when}, int'(sticky_ovf), 0, 0);
	endtask

	// walk rd_sel over all channels, one per cycle, sampling on the falling edge
	task automatic read_channels();
		for (int ch = 0; ch < NUM_CLOCKS; ch++) begin
			@(posedge ref_clk);
			rd_sel <= SEL_W'(ch);
			@(negedge ref_clk);
			got_count[ch] = int'(rd_count);
			got_ovf[ch]   = int'(rd_overflow);
			got_stop[ch]  = int'(rd_stopped);
		end
	endtask

	task automatic compare_channels();
		int raw;
		int tol;
		for (int ch = 0; ch < NUM_CLOCKS; ch++) begin
			raw = edges_in_gate(period_ns[ch]);
			// saturated and stopped counts are exact
			tol = (raw > COUNT_LIMIT || period_ns[ch] == 0) ? 0 : 1;
			check_value($sformatf("ch%0d count", ch), got_count[ch],
				expected_count(period_ns[ch]), tol);
			check_value($sformatf("ch%0d overflow", ch), got_ovf[ch], int'(raw > COUNT_LIMIT), 0);
			check_value($sformatf("ch%0d stopped", ch), got_stop[ch], int'(period_ns[ch] == 0), 0);
		end
	endtask

	// compare process, runs once per visible result
	always @(negedge ref_clk) begin
		if (rst_n && update) begin
			read_channels();
			if (armed) begin
				compare_channels();
			end
			gates_done++;
		end
	end

	// update spacing, counted in ref_clk cycles since reset was released
	always @(negedge ref_clk) begin
		if (!rst_n) begin
			cyc      = 0;
			last_upd = -1;
		end else begin
			cyc++;
			if (update && last_upd < 0) begin
				check_value("first update not before one gate", int'(cyc >= GATE_CYCLES), 1, 0);
			end else if (update) begin
				check_value("update spacing in cycles", cyc - last_upd, GATE_CYCLES, 0);
			end
			if (update) begin
				last_upd = cyc;
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("timeout: no end after %0d planned gates and a margin", PLANNED_GATES);
		$display("sim failed");
		$finish;
	end

	initial begin
		for (int ch = 0; ch < NUM_CLOCKS; ch++) begin
			random_period(ch);
		end
		repeat (8) begin
			@(negedge ref_clk);
			check_idle_outputs("during reset");
		end
		@(posedge ref_clk);
		rst_n <= 1'b1;
		repeat (4) begin
			@(negedge ref_clk);
			check_idle_outputs("after reset");
		end
		measure_after_change();

		// second set of random periods
		for (int ch = 0; ch < NUM_CLOCKS; ch++) begin
			random_period(ch);
		end
		measure_after_change();

		// channel 0 far too fast, channel 1 held still
		set_period(0, 1);
		set_period(1, 0);
		measure_after_change();
		@(negedge ref_clk);
		check_value("sticky_ovf after fast clock", int'(sticky_ovf), 1, 0);

		// back in range, the sticky bit has to survive until it is cleared
		random_period(0);
		random_period(1);
		measure_after_change();
		@(negedge ref_clk);
		check_value("sticky_ovf after slowing down", int'(sticky_ovf), 1, 0);
		@(posedge ref_clk);
		sticky_clr <= 1'b1;
		@(posedge ref_clk);
		sticky_clr <= 1'b0;
		@(negedge ref_clk);
		check_value("sticky_ovf after clear", int'(sticky_ovf), 0, 0);
		wait_gates(1);
		@(negedge ref_clk);
		check_value("sticky_ovf after in-range gate", int'(sticky_ovf), 0, 0);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule
